/* quarkPkg.sv */
/*
 * Quark RV32I shared definitions
 * Data widths, major opcodes, the two views of an instruction word
 * and the bundles passed between decoder, ALU, retire stage and sequencer
 */
package quarkPkg;

   localparam int XLEN = 32;                  // Data path width

   typedef logic [XLEN-1:0] xlenT;            // One data word
   typedef logic [4:0]      regIdT;           // Register index

   // Major opcodes taken from instruction bits 6..2
   localparam logic [4:0] OP_LOAD   = 5'b00000;
   localparam logic [4:0] OP_ALUIMM = 5'b00100;
   localparam logic [4:0] OP_AUIPC  = 5'b00101;
   localparam logic [4:0] OP_STORE  = 5'b01000;
   localparam logic [4:0] OP_ALUREG = 5'b01100;
   localparam logic [4:0] OP_LUI    = 5'b01101;
   localparam logic [4:0] OP_BRANCH = 5'b11000;
   localparam logic [4:0] OP_JALR   = 5'b11001;
   localparam logic [4:0] OP_JAL    = 5'b11011;

   // Register format view
   typedef struct packed {
      logic [6:0] funct7;
      regIdT      rs2;
      regIdT      rs1;
      logic [2:0] funct3;
      regIdT      rd;
      logic [6:0] opcode;
   } rFormatT;

   // Upper immediate view, LUI and AUIPC
   typedef struct packed {
      logic [19:0] imm20;
      regIdT       rd;
      logic [6:0]  opcode;
   } uFormatT;

   typedef union packed {
      rFormatT rFmt;
      uFormatT uFmt;
   } rvInstrT;

   typedef struct packed {
      logic       isLoad;
      logic       isStore;
      logic       isAluReg;
      logic       isAluImm;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
      logic       isLui;
      logic       isAuipc;
      logic [2:0] funct3;
      logic       aluSub;                     // SUB rather than ADD
      logic       shiftArith;                 // SRA/SRAI rather than logical
      regIdT      rd;
      xlenT       imm;                        // Immediate this opcode uses
   } decodedT;

   typedef struct packed {
      xlenT value;                            // ALU output
      xlenT addrSum;                          // rs1 + imm
      logic predicate;                        // Branch taken
      logic busy;                             // Serial shift running
   } aluResultT;

   typedef struct packed {
      xlenT       addr;
      xlenT       wdata;
      logic [3:0] wmask;
      logic       read;
   } memReqT;

endpackage

/* regFile.sv */
/*
 * Integer register file, 32 x 32 bits
 * Both operands are captured on the instruction latch cycle,
 * one write port, x0 hardwired to zero
 */
module regFile (
   input  logic            clk,
   input  quarkPkg::regIdT rs1Id,
   input  quarkPkg::regIdT rs2Id,
   input  logic            latch,
   input  logic            wen,
   input  quarkPkg::regIdT rd,
   input  quarkPkg::xlenT  wbData,
   output quarkPkg::xlenT  rs1,
   output quarkPkg::xlenT  rs2
);
   import quarkPkg::*;

   xlenT regs [32];

   always_ff @(posedge clk) begin
      if (wen && rd != '0) begin            // x0 never written
         regs[rd] <= wbData;
      end
   end

   // Operand capture, x0 forced to zero since its cell is never initialized
   always_ff @(posedge clk) begin
      if (latch) begin
         rs1 <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

/* instrDecoder.sv */
/*
 * Instruction decoder
 * Classifies the latched word into opcode classes and builds
 * the single immediate that the opcode needs
 */
module instrDecoder (
   input  quarkPkg::rvInstrT instr,
   output quarkPkg::decodedT dec
);
   import quarkPkg::*;

   logic [4:0]  opc;                        // Major opcode
   logic [31:0] w;                          // Raw bits for immediate scatter
   xlenT        iImm;
   xlenT        sImm;
   xlenT        bImm;
   xlenT        jImm;
   xlenT        uImm;

   assign opc = instr.rFmt.opcode[6:2];     // Bits 1..0 always 11 in RV32I
   assign w   = instr;

   // Sign bit is always instruction bit 31
   assign iImm = {{21{w[31]}}, w[30:20]};
   assign sImm = {{21{w[31]}}, w[30:25], w[11:7]};
   assign bImm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
   assign jImm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
   assign uImm = {instr.uFmt.imm20, 12'b0};

   always_comb begin
      dec.isLoad   = (opc == OP_LOAD);
      dec.isStore  = (opc == OP_STORE);
      dec.isAluReg = (opc == OP_ALUREG);
      dec.isAluImm = (opc == OP_ALUIMM);
      dec.isBranch = (opc == OP_BRANCH);
      dec.isJal    = (opc == OP_JAL);
      dec.isJalr   = (opc == OP_JALR);
      dec.isLui    = (opc == OP_LUI);
      dec.isAuipc  = (opc == OP_AUIPC);

      dec.funct3     = instr.rFmt.funct3;
      dec.shiftArith = instr.rFmt.funct7[5];          // Bit 30
      // ADDI reuses bit 30 as immediate, so only register ops may subtract
      dec.aluSub     = instr.rFmt.funct7[5] & dec.isAluReg;
      dec.rd         = instr.rFmt.rd;

      case (opc)
         OP_LUI,
         OP_AUIPC:  dec.imm = uImm;
         OP_STORE:  dec.imm = sImm;
         OP_BRANCH: dec.imm = bImm;
         OP_JAL:    dec.imm = jImm;
         default:   dec.imm = iImm;                   // ALU imm, load, JALR
      endcase
   end

endmodule

/* intAlu.sv */
/*
 * Integer ALU
 * Adder, one 33-bit subtractor shared by SUB and every compare,
 * logic ops, a one-bit-per-cycle shifter and the branch predicate
 */
module intAlu (
   input  logic                clk,
   input  logic                mem_rstrb,
   input  logic                start,
   input  quarkPkg::decodedT   dec,
   input  quarkPkg::xlenT      rs1,
   input  quarkPkg::xlenT      rs2,
   output quarkPkg::aluResultT res
);
   import quarkPkg::*;

   xlenT        in2;                        // Second operand
   xlenT        plus;
   logic [32:0] minus;
   logic        lt;
   logic        ltu;
   logic        eq;
   logic        isShift;
   xlenT        aluOut;
   logic        pred;
   xlenT        shReg;                      // Shift working register
   logic [4:0]  shamt;                      // Remaining shift steps

   assign in2 = (dec.isAluReg || dec.isBranch) ? rs2 : dec.imm;

   assign plus  = rs1 + in2;
   assign minus = {1'b1, ~in2} + {1'b0, rs1} + 33'd1;   // rs1 - in2, borrow in bit 32
   assign ltu   = minus[32];
   assign lt    = (rs1[31] ^ in2[31]) ? rs1[31] : minus[32];
   assign eq    = (minus[31:0] == '0);

   assign isShift = (dec.funct3[1:0] == 2'b01);    // SLL, SRL, SRA

   always_comb begin
      case (dec.funct3)
         3'b000:  aluOut = dec.aluSub ? minus[31:0] : plus;
         3'b010:  aluOut = {31'b0, lt};
         3'b011:  aluOut = {31'b0, ltu};
         3'b100:  aluOut = rs1 ^ in2;
         3'b110:  aluOut = rs1 | in2;
         3'b111:  aluOut = rs1 & in2;
         default: aluOut = shReg;                  // Shifts read the serial result
      endcase
   end

   // Branch conditions
   always_comb begin
      case (dec.funct3)
         3'b000:  pred = eq;                       // BEQ
         3'b001:  pred = ~eq;                      // BNE
         3'b100:  pred = lt;                       // BLT
         3'b101:  pred = ~lt;                      // BGE
         3'b110:  pred = ltu;                      // BLTU
         3'b111:  pred = ~ltu;                     // BGEU
         default: pred = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         shamt <= '0;
      end else if (start && isShift) begin
         shamt <= in2[4:0];
      end else if (shamt != '0) begin
         shamt <= shamt - 5'd1;
      end
   end

   // One bit per cycle, arithmetic right shift replicates the sign
   always_ff @(posedge clk) begin
      if (start && isShift) begin
         shReg <= rs1;
      end else if (shamt != '0) begin
         shReg <= dec.funct3[2] ? {dec.shiftArith & shReg[31], shReg[31:1]}
                                : {shReg[30:0], 1'b0};
      end
   end

   assign res.value     = aluOut;
   assign res.addrSum   = plus;                    // Same adder, imm is S or I form
   assign res.predicate = pred;
   assign res.busy      = (shamt != '0);

endmodule

/* retireUnit.sv */
/*
 * Retire stage
 * Picks the register write-back value and the next program counter
 */
module retireUnit #(
   parameter int ADDR_WIDTH = 24
) (
   input  quarkPkg::decodedT     dec,
   input  logic [ADDR_WIDTH-1:0] pc,
   input  quarkPkg::aluResultT   res,
   input  quarkPkg::xlenT        memRdata,
   output quarkPkg::xlenT        wbData,
   output logic [ADDR_WIDTH-1:0] nextPc
);
   import quarkPkg::*;

   logic [ADDR_WIDTH-1:0] pcPlus4;
   xlenT                  pcPlusImm;        // Branch, JAL and AUIPC target
   logic                  jumpImm;

   assign pcPlus4   = pc + ADDR_WIDTH'(4);
   assign pcPlusImm = xlenT'(pc) + dec.imm; // Full width so AUIPC keeps upper bits
   assign jumpImm   = dec.isJal | (dec.isBranch & res.predicate);

   always_comb begin
      if (dec.isLoad) begin
         wbData = memRdata;
      end else if (dec.isLui) begin
         wbData = dec.imm;
      end else if (dec.isAuipc) begin
         wbData = pcPlusImm;
      end else if (dec.isJal || dec.isJalr) begin
         wbData = xlenT'(pcPlus4);          // Link address
      end else begin
         wbData = res.value;                // Register and immediate ALU ops
      end
   end

   always_comb begin
      if (dec.isJalr) begin
         nextPc = {res.addrSum[ADDR_WIDTH-1:1], 1'b0};
      end else if (jumpImm) begin
         nextPc = pcPlusImm[ADDR_WIDTH-1:0];
      end else begin
         nextPc = pcPlus4;                  // Also SYSTEM and unknown opcodes
      end
   end

endmodule

/* fetchSequencer.sv */
/*
 * Fetch and execute sequencer
 * One-hot FSM over fetch, instruction wait, execute and ALU/memory wait,
 * owns the PC, the instruction latch and the memory request
 */
module fetchSequencer #(
   parameter int          ADDR_WIDTH = 24,
   parameter logic [31:0] RESET_ADDR = 32'h0
) (
   input  logic                  clk,
   input  logic                  mem_rstrb,
   input  quarkPkg::xlenT        memRdata,
   input  logic                  memRbusy,
   input  logic                  memWbusy,
   input  quarkPkg::decodedT     dec,
   input  quarkPkg::aluResultT   res,
   input  quarkPkg::xlenT        rs2,
   input  logic [ADDR_WIDTH-1:0] nextPc,
   output logic [ADDR_WIDTH-1:0] pc,
   output quarkPkg::rvInstrT     instr,
   output quarkPkg::regIdT       rs1Id,
   output quarkPkg::regIdT       rs2Id,
   output logic                  latch,
   output logic                  wen,
   output logic                  aluStart,
   output quarkPkg::memReqT      memReq
);
   import quarkPkg::*;

   // State bit positions
   localparam int FETCH           = 0;
   localparam int WAIT_INSTR      = 1;
   localparam int EXECUTE         = 2;
   localparam int WAIT_ALU_OR_MEM = 3;

   logic [3:0] state;                       // One-hot
   rvInstrT    fetched;                     // Word on the read bus
   logic       isAlu;
   logic       needWait;

   assign fetched = memRdata;
   assign rs1Id   = fetched.rFmt.rs1;       // Indices come straight off the bus
   assign rs2Id   = fetched.rFmt.rs2;
   assign latch   = state[WAIT_INSTR] & ~memRbusy;

   assign isAlu    = dec.isAluReg | dec.isAluImm;
   assign needWait = dec.isLoad | dec.isStore | (isAlu & (dec.funct3[1:0] == 2'b01));

   assign wen = (state[EXECUTE] | state[WAIT_ALU_OR_MEM]) &
                (isAlu | dec.isLui | dec.isAuipc | dec.isJal | dec.isJalr | dec.isLoad);
   assign aluStart = state[EXECUTE] & isAlu;

   // Memory request, PC during fetch, data address afterwards
   assign memReq.addr  = (state[FETCH] | state[WAIT_INSTR]) ? xlenT'(pc) : res.addrSum;
   assign memReq.wdata = rs2;
   assign memReq.wmask = {4{state[EXECUTE] & dec.isStore}};   // Word stores only
   assign memReq.read  = state[FETCH] | (state[EXECUTE] & dec.isLoad);

   always_ff @(posedge clk) begin
      if (mem_rstrb) begin
         state <= 4'(1 << WAIT_ALU_OR_MEM);  // Drain any pending write first
         pc    <= RESET_ADDR[ADDR_WIDTH-1:0];
      end else begin
         case (1'b1)
            state[WAIT_INSTR]: begin
               if (!memRbusy) state <= 4'(1 << EXECUTE);
            end
            state[EXECUTE]: begin
               pc    <= nextPc;
               state <= needWait ? 4'(1 << WAIT_ALU_OR_MEM) : 4'(1 << FETCH);
            end
            state[WAIT_ALU_OR_MEM]: begin
               if (!res.busy && !memRbusy && !memWbusy) state <= 4'(1 << FETCH);
            end
            default: state <= 4'(1 << WAIT_INSTR);   // FETCH
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (latch) begin
         instr <= fetched;
      end
   end

endmodule

/* quarkCore.sv */
/*
 * Quark RV32I core, top level
 * Ties sequencer, decoder, ALU, retire stage and register file
 * to one shared instruction/data memory port
 */
module quarkCore #(
   parameter int          ADDR_WIDTH = 24,
   parameter logic [31:0] RESET_ADDR = 32'h0
) (
   input  logic             clk,
   input  logic             mem_rstrb,
   input  quarkPkg::xlenT   memRdata,
   input  logic             memRbusy,
   input  logic             memWbusy,
   output quarkPkg::memReqT memReq
);
   import quarkPkg::*;

   rvInstrT               instr;
   decodedT               dec;
   aluResultT             res;
   xlenT                  rs1;
   xlenT                  rs2;
   xlenT                  wbData;
   regIdT                 rs1Id;
   regIdT                 rs2Id;
   logic                  latch;
   logic                  wen;
   logic                  aluStart;
   logic [ADDR_WIDTH-1:0] pc;
   logic [ADDR_WIDTH-1:0] nextPc;

   fetchSequencer #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .RESET_ADDR (RESET_ADDR)
   ) fetchSequencer_inst (
      .clk, .mem_rstrb, .memRdata, .memRbusy, .memWbusy,
      .dec, .res, .rs2, .nextPc, .pc, .instr,
      .rs1Id, .rs2Id, .latch, .wen, .aluStart, .memReq
   );

   instrDecoder instrDecoder_inst (.instr, .dec);

   regFile regFile_inst (
      .clk, .rs1Id, .rs2Id, .latch, .wen,
      .rd (dec.rd), .wbData, .rs1, .rs2
   );

   intAlu intAlu_inst (
      .clk, .mem_rstrb, .start (aluStart), .dec, .rs1, .rs2, .res
   );

   retireUnit #(
      .ADDR_WIDTH (ADDR_WIDTH)
   ) retireUnit_inst (
      .dec, .pc, .res, .memRdata, .wbData, .nextPc
   );

endmodule

/* tbMemory.sv */
/*
 * Testbench memory model
 * Word memory shared by fetch and data, random read and write busy,
 * reports each store to the testbench top
 */
module tbMemory (
   input  logic             clk,
   input  quarkPkg::memReqT memReq,
   output quarkPkg::xlenT   memRdata,
   output logic             memRbusy,
   output logic             memWbusy,
   output logic             storeStrobe,   // One cycle per completed store
   output quarkPkg::xlenT   storeAddr,
   output quarkPkg::xlenT   storeData
);
   timeunit 1ns;
   timeprecision 100ps;
   import quarkPkg::*;

   xlenT mem [1024];                        // 4 KiB, low two address bits ignored
   xlenT pendData;                          // Read word held back while busy
   int   rWait;
   int   wWait;

   initial begin
      memRdata    = '0;
      memRbusy    = 1'b0;
      memWbusy    = 1'b0;
      storeStrobe = 1'b0;
      storeAddr   = '0;
      storeData   = '0;
      rWait       = 0;
      wWait       = 0;
      for (int i = 0; i < 1024; i++) begin
         mem[i] = '0;
      end
   end

   // Preload from the testbench top
   task writeWord(input xlenT addr, input xlenT data);
      mem[addr[11:2]] = data;
   endtask

   // Reads, busy for 0 to 2 cycles, data is X until busy drops
   always @(posedge clk) begin
      if (memReq.read) begin
         pendData = mem[memReq.addr[11:2]];
         rWait    = $urandom % 3;
         memRbusy <= (rWait != 0);
         memRdata <= (rWait != 0) ? 'x : pendData;
      end else if (rWait != 0) begin
         rWait    = rWait - 1;
         memRbusy <= (rWait != 0);
         if (rWait == 0) memRdata <= pendData;
      end
   end

   // Word writes, busy raised from the next cycle
   always @(posedge clk) begin
      storeStrobe <= 1'b0;
      if (memReq.wmask == 4'hF) begin
         mem[memReq.addr[11:2]] <= memReq.wdata;
         storeStrobe <= 1'b1;
         storeAddr   <= memReq.addr;
         storeData   <= memReq.wdata;
         wWait       = $urandom % 3;
         memWbusy    <= (wWait != 0);
      end else if (wWait != 0) begin
         wWait    = wWait - 1;
         memWbusy <= (wWait != 0);
      end
   end

endmodule

/* tbQuarkCore.sv */
/*
 * Quark core testbench
 * Loads program and expected stores from the test data file,
 * checks every store in order under random memory stalls
 */
module tbQuarkCore;
   timeunit 1ns;
   timeprecision 100ps;
   import quarkPkg::*;

   localparam logic [31:0] RESET_ADDR = 32'h0;

   logic   clk;
   logic   mem_rstrb;
   xlenT   memRdata;
   logic   memRbusy;
   logic   memWbusy;
   memReqT memReq;
   logic   storeStrobe;
   xlenT   storeAddr;
   xlenT   storeData;

   string  expName [$];                     // Expected stores, in order
   xlenT   expAddr [$];
   xlenT   expData [$];
   int     storeIdx      = 0;
   int     instrLimit    = 0;
   int     cycles        = 0;
   logic   firstReadSeen = 1'b0;

   quarkCore #(
      .ADDR_WIDTH (24),
      .RESET_ADDR (RESET_ADDR)
   ) quarkCore_inst (
      .clk, .mem_rstrb, .memRdata, .memRbusy, .memWbusy, .memReq
   );

   tbMemory memInst (
      .clk, .memReq, .memRdata, .memRbusy, .memWbusy,
      .storeStrobe, .storeAddr, .storeData
   );

   always #2 clk = ~clk;                    // 4 ns period

   task abortRun(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task checkValue(input string name, input xlenT expected, input xlenT actual);
      if (expected !== actual) begin
         $display("[ERROR] %s expected %h actual %h", name, expected, actual);
         $display("*** FAILED ***");
         $fatal(1);
      end
   endtask

   // M addr word / E name addr data / N limit, # starts a comment
   task loadTestData;
      int    fd;
      int    n;
      string line;
      string name;
      xlenT  a;
      xlenT  d;
      fd = $fopen("quarkCore_testdata.txt", "r");
      if (fd == 0) begin
         abortRun("Cannot open quarkCore_testdata.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 0) begin
               case (line.getc(0))
                  "M": begin
                     n = $sscanf(line, "M %h %h", a, d);
                     memInst.writeWord(a, d);
                  end
                  "E": begin
                     n = $sscanf(line, "E %s %h %h", name, a, d);
                     expName.push_back(name);
                     expAddr.push_back(a);
                     expData.push_back(d);
                  end
                  "N": n = $sscanf(line, "N %d", instrLimit);
                  default: ;                // Comment or blank
               endcase
            end
         end
         $fclose(fd);
      end
   endtask

   // Timeout, 48 cycles per instruction covers a full shift plus stalls
   always @(posedge clk) begin
      cycles++;
      if (instrLimit > 0 && cycles >= instrLimit * 48) begin
         abortRun("Timeout, the expected stores did not all arrive");
      end
   end

   // Reset fetch address, no store may come before it
   always @(posedge clk) begin
      if (!mem_rstrb && !firstReadSeen) begin
         if (memReq.wmask != 4'h0) abortRun("Store seen before the first fetch");
         if (memReq.read) begin
            checkValue("RESET_FETCH", RESET_ADDR, memReq.addr);
            firstReadSeen <= 1'b1;
         end
      end
   end

   // Store order check
   always @(posedge clk) begin
      if (storeStrobe) begin
         if (storeIdx >= expName.size()) begin
            abortRun($sformatf("Extra store to %h with data %h", storeAddr, storeData));
         end
         checkValue({expName[storeIdx], " addr"}, expAddr[storeIdx], storeAddr);
         checkValue({expName[storeIdx], " data"}, expData[storeIdx], storeData);
         storeIdx++;
      end
   end

   initial begin
      void'($urandom(42810));
      clk       = 1'b0;
      mem_rstrb = 1'b1;
      loadTestData();
      repeat (3) @(posedge clk);
      mem_rstrb <= 1'b0;
      while (storeIdx < expName.size()) @(posedge clk);
      repeat (64) @(posedge clk);           // Core spins, any late store is extra
      if (storeIdx == expName.size() && firstReadSeen) begin
         $display("*** PASSED ***");
         $finish;
      end else begin
         $display("Store count or reset fetch check incomplete");
         $display("*** FAILED ***");
         $fatal(1);
      end
   end

endmodule

/* quarkCore_testdata.txt */
# M <addr> <word> program and data image, E <name> <addr> <data> expected store
# N <limit> instruction limit, all numbers hex except the limit
M 00000000 30000F93
M 00000004 06400093
M 00000008 FF900113
M 0000000C 002081B3
M 00000010 003FA023
M 00000014 40208233
M 00000018 004FA223
M 0000001C 001122B3
M 00000020 005FA423
M 00000024 00113333
M 00000028 006FA623
M 0000002C 0020C3B3
M 00000030 007FA823
M 00000034 0020E433
M 00000038 008FAA23
M 0000003C 0020F4B3
M 00000040 009FAC23
M 00000044 002FAE23
M 00000048 00109513
M 0000004C 02AFA023
M 00000050 01F11593
M 00000054 02BFA223
M 00000058 01F15613
M 0000005C 02CFA423
M 00000060 40115693
M 00000064 02DFA623
M 00000068 41F15713
M 0000006C 02EFA823
M 00000070 000157B3
M 00000074 02FFAA23
M 00000078 00115813
M 0000007C 030FAC23
M 00000080 000098B3
M 00000084 031FAE23
M 00000088 40015933
M 0000008C 052FA023
M 00000090 123459B7
M 00000094 053FA223
M 00000098 00001A17
M 0000009C 054FA423
M 000000A0 00800AEF
M 000000A4 001FA023
M 000000A8 055FA623
M 000000AC 0BC00B13
M 000000B0 001B0BE7
M 000000B4 001FA023
M 000000B8 001FA023
M 000000BC 057FA823
M 000000C0 00108463
M 000000C4 001FA023
M 000000C8 00208463
M 000000CC 043FAA23
M 000000D0 00209463
M 000000D4 001FA023
M 000000D8 00109463
M 000000DC 043FAC23
M 000000E0 00114463
M 000000E4 001FA023
M 000000E8 0020C463
M 000000EC 043FAE23
M 000000F0 0020D463
M 000000F4 001FA023
M 000000F8 00115463
M 000000FC 063FA023
M 00000100 0020E463
M 00000104 001FA023
M 00000108 00116463
M 0000010C 063FA223
M 00000110 00117463
M 00000114 001FA023
M 00000118 0020F463
M 0000011C 063FA423
M 00000120 20002C03
M 00000124 078FA623
M 00000128 20402C83
M 0000012C 079FA823
M 00000130 03700013
M 00000134 060FAA23
M 00000138 0000006F
M 00000200 CAFEF00D
M 00000204 80000001
E ADD 00000300 0000005D
E SUB 00000304 0000006B
E SLT 00000308 00000001
E SLTU 0000030C 00000000
E XOR 00000310 FFFFFF9D
E OR 00000314 FFFFFFFD
E AND 00000318 00000060
E ADDI 0000031C FFFFFFF9
E SLL_1 00000320 000000C8
E SLL_31 00000324 80000000
E SRL_31 00000328 00000001
E SRA_1 0000032C FFFFFFFC
E SRA_31 00000330 FFFFFFFF
E SRL_0 00000334 FFFFFFF9
E SRL_1 00000338 7FFFFFFC
E SLL_0 0000033C 00000064
E SRA_0 00000340 FFFFFFF9
E LUI 00000344 12345000
E AUIPC 00000348 00001098
E JAL_LINK 0000034C 000000A4
E JALR_LINK 00000350 000000B4
E BEQ_NT 00000354 0000005D
E BNE_NT 00000358 0000005D
E BLT_NT 0000035C 0000005D
E BGE_NT 00000360 0000005D
E BLTU_NT 00000364 0000005D
E BGEU_NT 00000368 0000005D
E LW_0 0000036C CAFEF00D
E LW_1 00000370 80000001
E X0_WRITE 00000374 00000000
N 90

/* sim.f */
quarkPkg.sv
regFile.sv
instrDecoder.sv
intAlu.sv
retireUnit.sv
fetchSequencer.sv
quarkCore.sv
tbMemory.sv
tbQuarkCore.sv
